//--- Bender.yml
package:
  name: motion_search

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/sse_pkg.sv
      - source/square_rom.sv
      - source/block_sse.sv
      - source/best_match_select.sv
      - source/motion_search_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - test/tb_motion_search.sv

//--- project.f
+incdir+source
source/sse_pkg.sv
source/square_rom.sv
source/block_sse.sv
source/best_match_select.sv
source/motion_search_top.sv
test/tb_motion_search.sv

//--- source/best_match_select.sv
// Best match selector
// Tracks the smallest SSE over a search and reports it with its
// candidate id once the last candidate has been scored

`timescale 1ns/1ps

module best_match_select
    import sse_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  sse_result_t result,
    input  logic        result_valid,
    output match_t      best,
    output logic        best_valid
);

    logic   have_best;
    match_t running;
    logic   take;
    match_t next_best;

    // ----------------------------------------------------------------------
    // Compare
    // ----------------------------------------------------------------------
    // Strictly smaller wins, so the earlier candidate keeps a tie
    assign take = !have_best || (result.sse < running.best_sse);

    always_comb begin
        if (take) begin
            next_best = '{best_sse: result.sse, best_id: result.tag.cand_id};
        end else begin
            next_best = running;
        end
    end

    // ----------------------------------------------------------------------
    // Running minimum and report
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_best <= 1'b0;
            running   <= '0;
        end else if (result_valid) begin
            running <= next_best;
            // A last candidate closes the search
            have_best <= !result.tag.last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best       <= '0;
            best_valid <= 1'b0;
        end else begin
            best_valid <= result_valid && result.tag.last;
            if (result_valid && result.tag.last) begin
                best <= next_best;
            end
        end
    end

endmodule

//--- source/block_sse.sv
// Block SSE engine
// Walks a 16x16 block pair one row per clock, squares the pixel
// differences through per-column lookup tables and accumulates the
// sum of squared errors for one candidate

`timescale 1ns/1ps
`include "sse_defines.svh"

module block_sse
    import sse_pkg::*;
(
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    cand_start,
    input  sse_tag_t                                                cand_tag,
    input  logic [`SSE_BLOCK_SIZE*`SSE_BLOCK_SIZE*`SSE_PIXEL_WIDTH-1:0] cur_block,
    input  logic [`SSE_BLOCK_SIZE*`SSE_BLOCK_SIZE*`SSE_PIXEL_WIDTH-1:0] cand_block,
    output logic                                                    busy,
    output sse_result_t                                             result,
    output logic                                                    result_valid
);

    localparam int ROW_W     = `SSE_BLOCK_SIZE * `SSE_PIXEL_WIDTH;
    localparam int ROW_CNT_W = $clog2(`SSE_BLOCK_SIZE);
    localparam int DIFF_W    = `SSE_PIXEL_WIDTH + 1;
    localparam int SQ_W      = 2 * `SSE_PIXEL_WIDTH;
    localparam int ROW_SUM_W = SQ_W + $clog2(`SSE_BLOCK_SIZE);

    sse_state_e            state;
    logic [ROW_CNT_W-1:0]  row_cnt;
    logic                  accept;
    logic                  load_row;
    logic                  last_row;
    logic                  addr_vld;
    logic                  addr_last;
    logic                  data_vld;
    logic                  data_last;
    logic [ROW_W-1:0]      cur_row;
    logic [ROW_W-1:0]      cand_row;
    logic [SQ_W-1:0]       sq_data [`SSE_BLOCK_SIZE];
    logic [ROW_SUM_W-1:0]  row_sum;
    logic [`SSE_WIDTH-1:0] acc;
    sse_tag_t              tag_q;

    // ----------------------------------------------------------------------
    // Row sequencing
    // ----------------------------------------------------------------------
    assign accept   = (state == SSE_IDLE) && cand_start;
    assign load_row = accept || (state == SSE_FEED);
    assign last_row = (state == SSE_FEED) &&
                      (row_cnt == ROW_CNT_W'(`SSE_BLOCK_SIZE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SSE_IDLE;
            row_cnt <= '0;
        end else begin
            case (state)
                SSE_IDLE: begin
                    if (cand_start) begin
                        state <= SSE_FEED;
                    end
                end
                SSE_FEED: begin
                    if (last_row) begin
                        state <= SSE_DRAIN;
                    end
                end
                SSE_DRAIN: begin
                    // Leave once the final row sum lands in the accumulator
                    if (data_last) begin
                        state <= SSE_IDLE;
                    end
                end
                default: state <= SSE_IDLE;
            endcase

            if (last_row) begin
                row_cnt <= '0;
            end else if (load_row) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    assign busy = (state != SSE_IDLE);

    // Current row of both blocks
    assign cur_row  = cur_block[row_cnt*ROW_W +: ROW_W];
    assign cand_row = cand_block[row_cnt*ROW_W +: ROW_W];

    // ----------------------------------------------------------------------
    // Per-column difference and square lookup
    // ----------------------------------------------------------------------
    for (genvar c = 0; c < `SSE_BLOCK_SIZE; c++) begin : g_col
        logic [`SSE_PIXEL_WIDTH-1:0] cur_pix;
        logic [`SSE_PIXEL_WIDTH-1:0] cand_pix;
        logic [DIFF_W-1:0]           diff_addr;

        assign cur_pix  = cur_row[c*`SSE_PIXEL_WIDTH +: `SSE_PIXEL_WIDTH];
        assign cand_pix = cand_row[c*`SSE_PIXEL_WIDTH +: `SSE_PIXEL_WIDTH];

        // Signed 9-bit difference is the table address
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                diff_addr <= '0;
            end else if (load_row) begin
                diff_addr <= {1'b0, cur_pix} - {1'b0, cand_pix};
            end
        end

        square_rom i_square_rom (
            .clk  (clk),
            .en   (addr_vld),
            .addr (diff_addr),
            .data (sq_data[c])
        );
    end

    // Pipeline markers for the address and table stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_vld     <= 1'b0;
            addr_last    <= 1'b0;
            data_vld     <= 1'b0;
            data_last    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            addr_vld     <= load_row;
            addr_last    <= last_row;
            data_vld     <= addr_vld;
            data_last    <= addr_last;
            result_valid <= data_last;
        end
    end

    // ----------------------------------------------------------------------
    // Row sum and accumulation
    // ----------------------------------------------------------------------
    always_comb begin
        row_sum = '0;
        for (int c = 0; c < `SSE_BLOCK_SIZE; c++) begin
            row_sum = row_sum + ROW_SUM_W'(sq_data[c]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc   <= '0;
            tag_q <= '0;
        end else if (accept) begin
            acc   <= '0;
            tag_q <= cand_tag;
        end else if (data_vld) begin
            acc <= acc + `SSE_WIDTH'(row_sum);
        end
    end

    assign result = '{sse: acc, tag: tag_q};

endmodule

//--- source/motion_search_top.sv
// Motion search distortion core
// SSE engine followed by the best-match selector; one candidate
// per start strobe, best result reported after the last one

`timescale 1ns/1ps
`include "sse_defines.svh"

module motion_search_top
    import sse_pkg::*;
(
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    cand_start,
    input  sse_tag_t                                                cand_tag,
    input  logic [`SSE_BLOCK_SIZE*`SSE_BLOCK_SIZE*`SSE_PIXEL_WIDTH-1:0] cur_block,
    input  logic [`SSE_BLOCK_SIZE*`SSE_BLOCK_SIZE*`SSE_PIXEL_WIDTH-1:0] cand_block,
    output logic                                                    busy,
    output sse_result_t                                             result,
    output logic                                                    result_valid,
    output match_t                                                  best,
    output logic                                                    best_valid
);

    // ----------------------------------------------------------------------
    // Distortion engine
    // ----------------------------------------------------------------------
    block_sse i_block_sse (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand_start   (cand_start),
        .cand_tag     (cand_tag),
        .cur_block    (cur_block),
        .cand_block   (cand_block),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    // ----------------------------------------------------------------------
    // Minimum search over candidates
    // ----------------------------------------------------------------------
    best_match_select i_best_match_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .result       (result),
        .result_valid (result_valid),
        .best         (best),
        .best_valid   (best_valid)
    );

endmodule

//--- source/square_rom.sv
// Square lookup table
// Maps a signed 9-bit pixel difference to its 16-bit square,
// with a registered read port

`timescale 1ns/1ps

module square_rom (
    input  logic        clk,
    input  logic        en,
    input  logic [8:0]  addr,
    output logic [15:0] data
);

    localparam int ADDR_W = 9;
    localparam int DATA_W = 16;
    localparam int DEPTH  = 1 << ADDR_W;

    logic [DATA_W-1:0] table_mem [DEPTH];

    // Address is read as two's complement
    // The code for -256 never occurs, so 16 bits hold every entry
    function automatic logic [DATA_W-1:0] square_of(input logic [ADDR_W-1:0] code);
        logic signed [ADDR_W-1:0]   value;
        logic signed [2*ADDR_W-1:0] prod;
        value = signed'(code);
        prod  = value * value;
        return prod[DATA_W-1:0];
    endfunction

    // Table contents fixed at elaboration
    for (genvar i = 0; i < DEPTH; i++) begin : g_entry
        assign table_mem[i] = square_of(ADDR_W'(i));
    end

    always_ff @(posedge clk) begin
        if (en) begin
            data <= table_mem[addr];
        end
    end

endmodule

//--- source/sse_defines.svh
// Motion search SSE core parameters
// Block geometry, pixel and result widths shared by the RTL

`ifndef SSE_DEFINES_SVH
`define SSE_DEFINES_SVH

// Pixels per row and rows per block
`define SSE_BLOCK_SIZE 16

// Bits per luma pixel
`define SSE_PIXEL_WIDTH 8

// Accumulated sum of squared errors
`define SSE_WIDTH 32

// Candidate label width
`define SSE_CAND_ID_WIDTH 6

`endif

//--- source/sse_pkg.sv
// Motion search SSE types
// Candidate tag, engine result, search outcome and engine states

`include "sse_defines.svh"

package sse_pkg;

    // ----------------------------------------------------------------------
    // Candidate label, travels with the candidate through the engine
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [`SSE_CAND_ID_WIDTH-1:0] cand_id;
        logic                          last;
    } sse_tag_t;

    // Per-candidate engine output
    typedef struct packed {
        logic [`SSE_WIDTH-1:0] sse;
        sse_tag_t              tag;
    } sse_result_t;

    // Outcome of one search
    typedef struct packed {
        logic [`SSE_WIDTH-1:0]         best_sse;
        logic [`SSE_CAND_ID_WIDTH-1:0] best_id;
    } match_t;

    // ----------------------------------------------------------------------
    // Engine sequencing
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        SSE_IDLE,
        SSE_FEED,
        SSE_DRAIN
    } sse_state_e;

endpackage

//--- test/tb_motion_search.sv
// Motion search core testbench
// Directed tests of the SSE engine and best-match selector, checked
// against a direct sum-of-squared-errors model

`timescale 1ns/1ps
`include "sse_defines.svh"

module tb_motion_search
    import sse_pkg::*;
();

    localparam int NUM_PIX = `SSE_BLOCK_SIZE * `SSE_BLOCK_SIZE;
    localparam int PIX_W   = `SSE_PIXEL_WIDTH;
    localparam int BLOCK_W = NUM_PIX * PIX_W;
    localparam int TIMEOUT = 40;
    localparam int LATENCY = 18;

    logic               clk;
    logic               rst_n;
    logic               cand_start;
    sse_tag_t           cand_tag;
    logic [BLOCK_W-1:0] cur_block;
    logic [BLOCK_W-1:0] cand_block;
    logic               busy;
    sse_result_t        result;
    logic               result_valid;
    match_t             best;
    logic               best_valid;

    int errors;
    int timeouts;
    int seed;

    motion_search_top i_motion_search_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand_start   (cand_start),
        .cand_tag     (cand_tag),
        .cur_block    (cur_block),
        .cand_block   (cand_block),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid),
        .best         (best),
        .best_valid   (best_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Reference model and helpers
    // ----------------------------------------------------------------------
    // Pixel p sits at bits 8p, which is row p/16, column p%16
    function automatic longint model_sse(input logic [BLOCK_W-1:0] a,
                                         input logic [BLOCK_W-1:0] b);
        longint sum;
        int     pa;
        int     pb;
        sum = 0;
        for (int p = 0; p < NUM_PIX; p++) begin
            pa = a[p*PIX_W +: PIX_W];
            pb = b[p*PIX_W +: PIX_W];
            sum += (pa - pb) * (pa - pb);
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic fill_random(output logic [BLOCK_W-1:0] blk);
        for (int p = 0; p < NUM_PIX; p++) begin
            blk[p*PIX_W +: PIX_W] = PIX_W'($urandom);
        end
    endtask

    task automatic fill_const(output logic [BLOCK_W-1:0] blk, input logic [PIX_W-1:0] value);
        for (int p = 0; p < NUM_PIX; p++) begin
            blk[p*PIX_W +: PIX_W] = value;
        end
    endtask

    // Every pixel toggled by the same mask
    task automatic offset_block(input logic [BLOCK_W-1:0] src, input logic [PIX_W-1:0] mask,
                                output logic [BLOCK_W-1:0] dst);
        for (int p = 0; p < NUM_PIX; p++) begin
            dst[p*PIX_W +: PIX_W] = src[p*PIX_W +: PIX_W] ^ mask;
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic pulse_start(input logic [5:0] id, input logic last);
        cand_tag   = '{cand_id: id, last: last};
        cand_start = 1'b1;
        step_cycle();
        cand_start = 1'b0;
    endtask

    task automatic wait_result(output sse_result_t res, output int cycles,
                               output logic busy_held);
        cycles    = 0;
        busy_held = 1'b1;
        res       = '0;
        while (!result_valid && cycles < TIMEOUT) begin
            if (!busy) begin
                busy_held = 1'b0;
            end
            step_cycle();
            cycles++;
        end
        if (result_valid) begin
            res = result;
        end else begin
            $display("Timeout: no result_valid within %0d cycles", TIMEOUT);
            timeouts++;
        end
    endtask

    // Latency counts clock edges from the start edge onward
    task automatic run_candidate(input logic [5:0] id, input logic last,
                                 output sse_result_t res, output int latency,
                                 output logic busy_held);
        pulse_start(id, last);
        wait_result(res, latency, busy_held);
        latency++;
    endtask

    // One search; candidates near_a and near_b are the current block offset by mask
    task automatic run_search(input int base_id, input int count, input int near_a,
                              input int near_b, input logic [PIX_W-1:0] mask,
                              input string name);
        sse_result_t res;
        int          lat;
        logic        held;
        logic [63:0] sse_exp;
        logic [63:0] exp_min;
        int          exp_id;
        exp_min = '0;
        exp_id  = 0;
        fill_random(cur_block);
        for (int k = 0; k < count; k++) begin
            if (k == near_a || k == near_b) begin
                offset_block(cur_block, mask, cand_block);
            end else begin
                fill_random(cand_block);
            end
            sse_exp = model_sse(cur_block, cand_block);
            // First one always taken, later ones only when strictly smaller
            if (k == 0 || sse_exp < exp_min) begin
                exp_min = sse_exp;
                exp_id  = base_id + k;
            end
            run_candidate(6'(base_id + k), k == count - 1, res, lat, held);
            check_value($sformatf("%s_sse_%0d", name, k), sse_exp, res.sse);
        end
        check_value({name, "_best_valid_early"}, 0, best_valid);
        step_cycle();
        check_value({name, "_best_valid"}, 1, best_valid);
        check_value({name, "_best_id"}, exp_id, best.best_id);
        check_value({name, "_best_sse"}, exp_min, best.best_sse);
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_identical();
        sse_result_t res;
        int          lat;
        logic        held;
        fill_random(cur_block);
        cand_block = cur_block;
        run_candidate(6'd37, 1'b1, res, lat, held);
        check_value("identical_sse", 0, res.sse);
        check_value("identical_id", 37, res.tag.cand_id);
        check_value("identical_last", 1, res.tag.last);
    endtask

    // Differences 1, -3, 200, then 0 against 255
    task automatic test_constant_diff();
        sse_result_t res;
        int          lat;
        logic        held;
        int          cur_val [4];
        int          cand_val [4];
        longint      expected;
        cur_val  = '{101, 50, 220, 0};
        cand_val = '{100, 53, 20, 255};
        for (int k = 0; k < 4; k++) begin
            fill_const(cur_block, cur_val[k]);
            fill_const(cand_block, cand_val[k]);
            expected = longint'(NUM_PIX) * (cur_val[k] - cand_val[k]) * (cur_val[k] - cand_val[k]);
            run_candidate(6'(k), 1'b1, res, lat, held);
            check_value($sformatf("constant_diff_%0d", cur_val[k] - cand_val[k]),
                        expected, res.sse);
        end
        check_value("full_scale", 16646400, res.sse);
    endtask

    task automatic test_random_pairs();
        sse_result_t res;
        int          lat;
        logic        held;
        for (int k = 0; k < 10; k++) begin
            fill_random(cur_block);
            fill_random(cand_block);
            run_candidate(6'(k + 16), 1'b1, res, lat, held);
            check_value($sformatf("random_pair_%0d", k), model_sse(cur_block, cand_block),
                        res.sse);
        end
    endtask

    task automatic test_latency_busy();
        sse_result_t res;
        int          lat;
        logic        held;
        int          extra;
        fill_random(cur_block);
        fill_random(cand_block);
        run_candidate(6'd50, 1'b1, res, lat, held);
        check_value("latency_cycles", LATENCY, lat);
        check_value("latency_busy_held", 1, held);
        check_value("latency_busy_at_result", 0, busy);
        step_cycle();
        check_value("latency_valid_pulse", 0, result_valid);
        check_value("latency_busy_after", 0, busy);

        // Second strobe lands while the engine is busy
        pulse_start(6'd51, 1'b1);
        for (int i = 0; i < 3; i++) begin
            step_cycle();
        end
        pulse_start(6'd52, 1'b1);
        wait_result(res, lat, held);
        check_value("ignored_start_id", 51, res.tag.cand_id);
        extra = 0;
        for (int i = 0; i < TIMEOUT; i++) begin
            step_cycle();
            if (result_valid) begin
                extra++;
            end
        end
        check_value("ignored_start_extra", 0, extra);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        seed       = $urandom(7);
        errors     = 0;
        timeouts   = 0;
        rst_n      = 1'b0;
        cand_start = 1'b0;
        cand_tag   = '0;
        cur_block  = '0;
        cand_block = '0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        #10;
        rst_n = 1'b1;
        check_value("reset_busy", 0, busy);
        check_value("reset_result_valid", 0, result_valid);
        check_value("reset_best_valid", 0, best_valid);

        test_identical();
        test_constant_diff();
        test_random_pairs();
        test_latency_busy();
        // Tie between ids 9 and 11, the earlier one should win
        run_search(8, 5, 1, 3, 8'h01, "search_first");
        // Minimum of 4096 here, above the 256 of the first search
        run_search(40, 3, 1, 1, 8'h04, "search_second");

        $display("Errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
